// File: all.f
verilog/sched_cfg_pkg.sv
verilog/sched_req_pkg.sv
verilog/rand_lfsr.sv
verilog/req_hold.sv
verilog/rr_arb_windex.sv
verilog/rand_sched.sv
bench/sched_tb_clk.sv
bench/rand_sched_asserts.sv
bench/rand_sched_tb.sv

// File: bench/rand_sched_asserts.sv
// Scheduler protocol assertions

module rand_sched_asserts
  import sched_cfg_pkg::*;
#(
  parameter int NUM_REQS = NUM_REQS_DEFAULT
) (
  input logic                            clk,
  input logic                            rst,
  input logic [NUM_REQS-1:0]             push,
  input logic                            take,
  input logic [NUM_REQS-1:0]             full,
  input logic                            grant_v,
  input logic [idx_width(NUM_REQS)-1:0]  grant_id
);

  // Number of assertion failures, read by the testbench at the end
  int failures = 0;

  // Reset empties every slot, so no grant can follow it
  a_idle_after_reset: assert property (@(posedge clk) rst |=> !grant_v)
    else begin
      $error("grant_v high in the cycle after reset");
      failures++;
    end

  // A presented grant always points at a held slot
  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    grant_v |-> full[grant_id])
    else begin
      $error("grant_id points at a slot that is not held");
      failures++;
    end

  // An accepted slot empties unless it was pushed again in the same cycle
  a_accept_clears: assert property (@(posedge clk) disable iff (rst)
    (grant_v && take && !push[grant_id]) |=> !full[$past(grant_id)])
    else begin
      $error("accepted slot still held in the next cycle");
      failures++;
    end

  // There is a grant exactly when some slot is held
  a_grant_any: assert property (@(posedge clk) disable iff (rst)
    grant_v == (|full))
    else begin
      $error("grant_v disagrees with the held slots");
      failures++;
    end

endmodule

bind rand_sched rand_sched_asserts #(
  .NUM_REQS  (NUM_REQS)
) i_rand_sched_asserts (
  .clk       (clk),
  .rst       (rst),
  .push      (push),
  .take      (take),
  .full      (full),
  .grant_v   (grant_v),
  .grant_id  (grant_id)
);

// File: bench/rand_sched_tb.sv
// Scheduler testbench
// Directed tests against a cycle model

module rand_sched_tb
  import sched_cfg_pkg::*;
  import sched_req_pkg::*;
;

  localparam int         NUM_REQS = 8;
  localparam logic [7:0] SEED     = 8'h01;
  localparam int         IW       = idx_width(NUM_REQS);
  localparam int         PERIOD   = 8;

  // Cycles used by each test, reset included
  localparam int CYC_RESET   = 5;
  localparam int CYC_IDLE    = 4;
  localparam int CYC_SINGLE  = 3;
  localparam int CYC_ALL     = 9;
  localparam int CYC_BACK    = 15;
  localparam int CYC_HELD    = 3;
  localparam int CYC_RANDOM  = 300 + NUM_REQS;
  localparam int CYC_TOTAL   = CYC_RESET + CYC_IDLE + CYC_SINGLE + CYC_ALL +
                               CYC_BACK + CYC_HELD + CYC_RANDOM;
  localparam int WATCHDOG    = CYC_TOTAL * PERIOD + 40 * PERIOD;

  logic                          clk;
  logic                          rst;
  logic         [NUM_REQS-1:0]   push;
  req_payload_t [NUM_REQS-1:0]   push_data;
  logic                          take;
  logic         [NUM_REQS-1:0]   full;
  logic                          grant_v;
  logic         [IW-1:0]         grant_id;
  req_payload_t                  grant_data;

  // Reference state: LFSR, slot valid bits and slot payloads
  logic         [7:0]            model_lfsr;
  logic         [NUM_REQS-1:0]   model_valid;
  req_payload_t                  model_data [NUM_REQS];

  // Grant seen in the most recent cycle, already checked against the model
  logic                          seen_v;
  logic         [IW-1:0]         seen_id;
  req_payload_t                  seen_data;

  sched_tb_clk #(
    .PERIOD  (PERIOD)
  ) i_sched_tb_clk (
    .clk     (clk)
  );

  rand_sched #(
    .NUM_REQS    (NUM_REQS),
    .SEED        (SEED)
  ) i_rand_sched (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .push_data   (push_data),
    .take        (take),
    .full        (full),
    .grant_v     (grant_v),
    .grant_id    (grant_id),
    .grant_data  (grant_data)
  );

  // One LFSR step, shift left with taps 7, 5, 4 and 3 into bit 0
  function automatic logic [7:0] lfsr_next(input logic [7:0] cur);
    return {cur[6:0], cur[7] ^ cur[5] ^ cur[4] ^ cur[3]};
  endfunction

  function automatic req_payload_t make_payload(input logic [3:0] tag,
                                                input logic [11:0] len);
    return {tag, len};
  endfunction

  // First held slot at or after the start index, with wrap-around
  function automatic void model_grant(output logic v, output logic [IW-1:0] id);
    int j;
    v  = 1'b0;
    id = '0;
    for (int k = 0; k < NUM_REQS; k++) begin
      j = (int'(model_lfsr[IW-1:0]) + k) % NUM_REQS;
      if (!v && model_valid[j]) begin
        v  = 1'b1;
        id = IW'(j);
      end
    end
  endfunction

  task automatic check_val(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else begin
        $display("CHECK FAILED test %s %s expected %0h actual %0h", test, what, exp, act);
        $display("Errors found");
        $fatal(1);
      end
  endtask

  // Drive one cycle, compare at the falling edge, then advance the model
  // Entered and left 1 time unit after a rising edge
  task automatic run_cycle(input string test, input logic [NUM_REQS-1:0] p,
                           input req_payload_t [NUM_REQS-1:0] pd, input logic t);
    logic                exp_v;
    logic [IW-1:0]       exp_id;
    logic [NUM_REQS-1:0] cleared;
    push      = p;
    push_data = pd;
    take      = t;
    @(negedge clk);
    model_grant(exp_v, exp_id);
    check_val(test, "full", model_valid, full);
    check_val(test, "grant_v", exp_v, grant_v);
    if (exp_v) begin
      check_val(test, "grant_id", exp_id, grant_id);
      check_val(test, "grant_data", model_data[exp_id], grant_data);
    end
    seen_v    = grant_v;
    seen_id   = grant_id;
    seen_data = grant_data;
    @(posedge clk);
    cleared = '0;
    // Only an accepted grant clears its slot and steps the LFSR
    if (exp_v && t) begin
      cleared[exp_id] = 1'b1;
      model_lfsr      = lfsr_next(model_lfsr);
    end
    for (int i = 0; i < NUM_REQS; i++) begin
      if (p[i] && (!model_valid[i] || cleared[i])) begin
        model_valid[i] = 1'b1;
        model_data[i]  = pd[i];
      end else if (cleared[i]) begin
        model_valid[i] = 1'b0;
      end
    end
    #1;
  endtask

  task automatic idle_cycles(input string test, input int n, input logic t);
    repeat (n) begin
      run_cycle(test, '0, '0, t);
    end
  endtask

  task automatic test_reset_idle();
    check_val("reset_idle", "full", 0, full);
    check_val("reset_idle", "grant_v", 0, grant_v);
    idle_cycles("reset_idle", CYC_IDLE, 1'b1);
  endtask

  task automatic test_single_push();
    req_payload_t [NUM_REQS-1:0] pd;
    pd    = '0;
    pd[3] = make_payload(4'ha, 12'h123);
    run_cycle("single_push", 8'h08, pd, 1'b0);
    // The slot shows up as the grant one cycle after the push
    run_cycle("single_push", '0, '0, 1'b1);
    check_val("single_push", "grant_id", 3, seen_id);
    check_val("single_push", "grant_data", pd[3], seen_data);
    run_cycle("single_push", '0, '0, 1'b0);
    check_val("single_push", "full", 0, full);
  endtask

  // Pushes every source, then drains with take high or after a stall
  task automatic drain_all(input string test, input int stall);
    req_payload_t [NUM_REQS-1:0] pd;
    logic         [NUM_REQS-1:0] served;
    logic         [IW-1:0]       first_id;
    req_payload_t                first_data;
    for (int i = 0; i < NUM_REQS; i++) begin
      pd[i] = make_payload(4'(i + stall), 12'(12'h100 + i * 17 + stall));
    end
    run_cycle(test, '1, pd, 1'b0);
    if (stall > 0) begin
      run_cycle(test, '0, '0, 1'b0);
      first_id   = seen_id;
      first_data = seen_data;
      // Back-pressure keeps the slots and the LFSR, so the grant must not move
      repeat (stall - 1) begin
        run_cycle(test, '0, '0, 1'b0);
        check_val(test, "stalled grant_id", first_id, seen_id);
        check_val(test, "stalled grant_data", first_data, seen_data);
      end
    end
    served = '0;
    repeat (NUM_REQS) begin
      run_cycle(test, '0, '0, 1'b1);
      check_val(test, "grant_v", 1, seen_v);
      check_val(test, "served twice", 0, served[seen_id]);
      served[seen_id] = 1'b1;
    end
    check_val(test, "served", {NUM_REQS{1'b1}}, served);
    check_val(test, "full", 0, full);
  endtask

  task automatic test_held_push();
    req_payload_t [NUM_REQS-1:0] pd_a;
    req_payload_t [NUM_REQS-1:0] pd_b;
    pd_a    = '0;
    pd_b    = '0;
    pd_a[5] = make_payload(4'h3, 12'h0aa);
    pd_b[5] = make_payload(4'hc, 12'hf55);
    run_cycle("held_push", 8'h20, pd_a, 1'b0);
    // Second push to the same slot while it is still held
    run_cycle("held_push", 8'h20, pd_b, 1'b0);
    run_cycle("held_push", '0, '0, 1'b1);
    check_val("held_push", "grant_id", 5, seen_id);
    check_val("held_push", "grant_data", pd_a[5], seen_data);
    check_val("held_push", "full", 0, full);
  endtask

  task automatic test_random();
    req_payload_t [NUM_REQS-1:0] pd;
    logic         [NUM_REQS-1:0] p;
    logic                        t;
    repeat (300) begin
      // Two masks ANDed keep each source at about one push in four cycles
      p = NUM_REQS'($urandom) & NUM_REQS'($urandom);
      for (int i = 0; i < NUM_REQS; i++) begin
        pd[i] = req_payload_t'($urandom);
      end
      t = ($urandom % 4) != 0;
      run_cycle("random", p, pd, t);
    end
    idle_cycles("random", NUM_REQS, 1'b1);
    check_val("random", "full", 0, full);
  endtask

  initial begin
    void'($urandom(32'hb44561a2));
    rst         = 1'b1;
    push        = '0;
    push_data   = '0;
    take        = 1'b0;
    model_lfsr  = SEED;
    model_valid = '0;
    for (int i = 0; i < NUM_REQS; i++) begin
      model_data[i] = '0;
    end
    repeat (CYC_RESET) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_idle();
    test_single_push();
    drain_all("all_sources", 0);
    drain_all("backpressure", 6);
    test_held_push();
    test_random();
    if (i_rand_sched.i_rand_sched_asserts.failures == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times",
               i_rand_sched.i_rand_sched_asserts.failures);
      $display("Errors found");
      $fatal(1);
    end
  end

  // Stops the run as soon as a bound protocol assertion fails
  always @(i_rand_sched.i_rand_sched_asserts.failures) begin
    if (i_rand_sched.i_rand_sched_asserts.failures != 0) begin
      $display("A protocol assertion on the scheduler failed");
      $display("Errors found");
      $fatal(1);
    end
  end

  // Ends a hung run after the summed test length plus a margin
  initial begin
    #(WATCHDOG);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Errors found");
    $fatal(1);
  end

endmodule

// File: bench/sched_tb_clk.sv
// Testbench clock source

module sched_tb_clk #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  // Free running clock, low for the first half period
  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

// File: verilog/rand_lfsr.sv
// Random start index source
// 8-bit LFSR stepped by an update strobe

module rand_lfsr
  import sched_cfg_pkg::*;
#(
  parameter logic [LFSR_WIDTH-1:0] SEED = SEED_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  update,
  output logic [LFSR_WIDTH-1:0] random
);

  // A zero seed would leave the register stuck at zero forever
  if (SEED == '0) begin : g_bad_seed
    $error("rand_lfsr SEED must be nonzero");
  end

  // Current LFSR state
  logic [LFSR_WIDTH-1:0] lfsr;

  // Feedback bit for x^8+x^6+x^5+x^4+1
  logic                  feedback;

  // Taps at bits 7, 5, 4 and 3 of the current state
  assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

  // The state only moves when a grant is accepted
  // Between updates the start index stays put so the grant is stable
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= SEED;
    end else if (update) begin
      // Shift left and bring the feedback in at bit 0
      lfsr <= {lfsr[LFSR_WIDTH-2:0], feedback};
    end
  end

  // The whole register goes out; the consumer picks the bits it needs
  assign random = lfsr;

endmodule

// File: verilog/rand_sched.sv
// Randomized request scheduler
// LFSR start index with round-robin search

module rand_sched
  import sched_cfg_pkg::*;
  import sched_req_pkg::*;
#(
  parameter int              NUM_REQS = NUM_REQS_DEFAULT,
  parameter logic [LFSR_WIDTH-1:0] SEED = SEED_DEFAULT
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic         [NUM_REQS-1:0]            push,
  input  req_payload_t [NUM_REQS-1:0]            push_data,
  input  logic                                   take,
  output logic         [NUM_REQS-1:0]            full,
  output logic                                   grant_v,
  output logic         [idx_width(NUM_REQS)-1:0] grant_id,
  output req_payload_t                           grant_data
);

  localparam int IW = idx_width(NUM_REQS);

  // The start index is a slice of the LFSR, so the source count must fit it
  if (!num_reqs_ok(NUM_REQS)) begin : g_bad_num_reqs
    $error("rand_sched NUM_REQS must be a power of two from 2 to 256");
  end

  // LFSR state
  logic         [LFSR_WIDTH-1:0] random;

  // Search start index taken from the low LFSR bits
  logic         [IW-1:0]         index;

  // Grant presented and taken in the same cycle
  logic                          accept;

  // Payloads of all slots
  req_payload_t [NUM_REQS-1:0]   held_data;

  // A grant counts only when there is one to take
  assign accept = grant_v & take;

  assign index = random[IW-1:0];

  // Start index source, stepped once per accepted grant
  rand_lfsr #(
    .SEED    (SEED)
  ) i_rand_lfsr (
    .clk     (clk),
    .rst     (rst),
    .update  (accept),
    .random  (random)
  );

  // Holding slots, the accepted source is cleared by its id
  req_hold #(
    .NUM_REQS   (NUM_REQS)
  ) i_req_hold (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_data  (push_data),
    .clear      (accept),
    .clear_id   (grant_id),
    .held       (full),
    .held_data  (held_data)
  );

  // Combinational winner search over the registered slots
  rr_arb_windex #(
    .NUM_REQS    (NUM_REQS)
  ) i_rr_arb_windex (
    .held        (full),
    .held_data   (held_data),
    .index       (index),
    .grant_v     (grant_v),
    .grant_id    (grant_id),
    .grant_data  (grant_data)
  );

endmodule

// File: verilog/req_hold.sv
// Request holding slots
// One valid bit and payload per source

module req_hold
  import sched_cfg_pkg::*;
  import sched_req_pkg::*;
#(
  parameter int NUM_REQS = NUM_REQS_DEFAULT
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic         [NUM_REQS-1:0]            push,
  input  req_payload_t [NUM_REQS-1:0]            push_data,
  input  logic                                   clear,
  input  logic         [idx_width(NUM_REQS)-1:0] clear_id,
  output logic         [NUM_REQS-1:0]            held,
  output req_payload_t [NUM_REQS-1:0]            held_data
);

  // Valid bit per slot
  logic         [NUM_REQS-1:0] valid;

  // Stored payload per slot
  req_payload_t [NUM_REQS-1:0] data;

  // Slot addressed by the clear strobe, one-hot
  logic         [NUM_REQS-1:0] clear_sel;

  // Clear that actually hits a held slot
  logic         [NUM_REQS-1:0] clear_hit;

  // Push that is allowed to load the slot
  logic         [NUM_REQS-1:0] load;

  // Decode the cleared source number into a one-hot vector
  always_comb begin
    clear_sel = '0;
    if (clear) begin
      clear_sel[clear_id] = 1'b1;
    end
  end

  // A clear on an empty slot is dropped
  assign clear_hit = clear_sel & valid;

  // An empty slot takes any push
  // A slot being cleared this cycle is free again and may reload at once
  // A push to a slot that stays held is ignored and the old payload is kept
  assign load = push & (~valid | clear_hit);

  for (genvar i = 0; i < NUM_REQS; i++) begin : g_slot

    // Valid bit of this slot, the only control state here
    always_ff @(posedge clk) begin
      if (rst) begin
        valid[i] <= 1'b0;
      end else if (load[i]) begin
        valid[i] <= 1'b1;
      end else if (clear_hit[i]) begin
        valid[i] <= 1'b0;
      end
    end

    // Payload register, only written on a load
    always_ff @(posedge clk) begin
      if (load[i]) begin
        data[i] <= push_data[i];
      end
    end

  end

  // Registered slot contents feed the arbiter
  assign held      = valid;
  assign held_data = data;

endmodule

// File: verilog/rr_arb_windex.sv
// Round-robin search from an external index
// Picks the winner and its payload

module rr_arb_windex
  import sched_cfg_pkg::*;
  import sched_req_pkg::*;
#(
  parameter int NUM_REQS = NUM_REQS_DEFAULT
) (
  input  logic         [NUM_REQS-1:0]            held,
  input  req_payload_t [NUM_REQS-1:0]            held_data,
  input  logic         [idx_width(NUM_REQS)-1:0] index,
  output logic                                   grant_v,
  output logic         [idx_width(NUM_REQS)-1:0] grant_id,
  output req_payload_t                           grant_data
);

  localparam int IW = idx_width(NUM_REQS);

  // Held vector written twice so a plain slice gives the rotation
  logic [2*NUM_REQS-1:0] held_dbl;

  // Held vector rotated so that bit k is source (index + k) mod NUM_REQS
  logic [NUM_REQS-1:0]   held_rot;

  // Offset of the first held slot counting up from index
  logic [IW-1:0]         offset;

  // Set once the search has seen a held slot
  logic                  found;

  // Rotate right by index
  // The upper copy supplies the bits that wrap around past the top source
  always_comb begin
    held_dbl = {held, held};
    held_rot = held_dbl[index +: NUM_REQS];
  end

  // Lowest set bit of the rotated vector
  // Earlier hits win, later ones are masked by found
  always_comb begin
    offset = '0;
    found  = 1'b0;
    for (int k = 0; k < NUM_REQS; k++) begin
      if (held_rot[k] && !found) begin
        found  = 1'b1;
        offset = IW'(k);
      end
    end
  end

  // Any held slot gives a grant, whatever the index
  assign grant_v = found;

  // Undo the rotation to get the source number
  // NUM_REQS is a power of two, so the IW-bit sum wraps exactly at NUM_REQS
  assign grant_id = index + offset;

  // Payload of the chosen source
  // With nothing held this is slot index's stale payload, and grant_v is low
  assign grant_data = held_data[grant_id];

endmodule

// File: verilog/sched_cfg_pkg.sv
// Scheduler configuration
// Sizing constants and helpers

package sched_cfg_pkg;

  // Number of request sources when the top level is left at its default
  localparam int NUM_REQS_DEFAULT = 8;

  // Starting value of the 8-bit LFSR
  // An all-zero value would lock the register, so the seed must be nonzero
  localparam logic [7:0] SEED_DEFAULT = 8'h01;

  // Width of the LFSR that drives the starting index
  localparam int LFSR_WIDTH = 8;

  // Number of bits needed to number num_reqs sources
  // At least one bit is returned so a two-source scheduler still has an id
  function automatic int idx_width(input int num_reqs);
    int bits;
    bits = 1;
    // Grow until 2**bits covers every source number
    while ((1 << bits) < num_reqs) begin
      bits++;
    end
    return bits;
  endfunction

  // True when n is a power of two in the supported range
  function automatic bit num_reqs_ok(input int n);
    return (n >= 2) && (n <= (1 << LFSR_WIDTH)) && ((n & (n - 1)) == 0);
  endfunction

endpackage

// File: verilog/sched_req_pkg.sv
// Scheduler request payload

package sched_req_pkg;

  // Width of the tag field
  localparam int TAG_WIDTH = 4;

  // Width of the length field
  localparam int LEN_WIDTH = 12;

  // One request as posted by a source
  // The tag sits in the upper nibble, the length in the lower 12 bits
  // The scheduler never looks inside, it only stores and forwards it
  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic [LEN_WIDTH-1:0] length;
  } req_payload_t;

  // Total payload width, 16 bits with the fields above
  localparam int PAYLOAD_WIDTH = $bits(req_payload_t);

endpackage
